// File: design/blur_pkg.sv
package blur_pkg;

    // Pixel format, RGB444 packed as red, green, blue from the top bit down
    localparam int chan_w = 4;
    localparam int pix_w = 12;

    // Image geometry
    localparam int line_len = 320;
    localparam int max_k = 7;

    // 15 times the largest weight total (1920) fits in 11 bits
    localparam int sum_w = 11;

    // Weight table of the 7x7 kernel
    // The 3x3 and 5x5 kernels use its centered squares, with totals 32, 64 and 128
    localparam logic [2:0] kernel_weights [max_k][max_k] = '{
        '{2, 2, 3, 4, 3, 2, 2},
        '{2, 1, 2, 3, 2, 1, 2},
        '{3, 2, 3, 4, 3, 2, 3},
        '{4, 3, 4, 4, 4, 3, 4},
        '{3, 2, 3, 4, 3, 2, 3},
        '{2, 1, 2, 3, 2, 1, 2},
        '{2, 2, 3, 4, 3, 2, 2}
    };

    // Kernel selection, the value is also the kernel radius
    typedef enum logic [1:0] {
        mode_bypass,
        mode_k3,
        mode_k5,
        mode_k7
    } blur_mode_t;

    typedef struct packed {
        logic [chan_w-1:0] r;
        logic [chan_w-1:0] g;
        logic [chan_w-1:0] b;
    } rgb_t;

    // Raw word for the bypass path, channels for the blur path
    typedef union packed {
        logic [pix_w-1:0] raw;
        rgb_t             rgb;
    } pixel_u;

    // Control that travels with one accepted pixel
    typedef struct packed {
        logic       valid;
        logic       sop;
        logic       eop;
        blur_mode_t mode;
    } stream_ctrl_t;

    // Indexed [row][column], row 0 is the oldest line, column 6 the newest pixel
    typedef logic [max_k-1:0][max_k-1:0][chan_w-1:0] chan_window_t;

    typedef logic [sum_w-1:0] chan_sum_t;

endpackage

// File: design/window_buffer.sv
`timescale 1ns/10ps

module window_buffer #(
    parameter int line_len_p = blur_pkg::line_len
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   valid_in,
    input  logic                   ready_in,
    input  logic                   sop_in,
    input  logic                   eop_in,
    input  blur_pkg::blur_mode_t   kernel_sel,
    input  blur_pkg::pixel_u       pixel_in,
    output blur_pkg::chan_window_t win_r,
    output blur_pkg::chan_window_t win_g,
    output blur_pkg::chan_window_t win_b,
    output blur_pkg::stream_ctrl_t win_ctrl,
    output blur_pkg::pixel_u       win_pixel
);
    import blur_pkg::*;

    logic                          accept;
    logic [$clog2(line_len_p)-1:0] col_ptr;

    // Six line delays, memory k feeds window row k
    rgb_t line_mem [max_k-1][line_len_p];
    rgb_t feed [max_k];

    assign accept = valid_in && ready_in;

    // Newest row takes the incoming pixel, each older row reads one line further back
    always_comb begin
        feed[max_k-1] = pixel_in.rgb;
        for (int k = 0; k < max_k - 1; k++) begin
            feed[k] = line_mem[k][col_ptr];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            col_ptr  <= '0;
            win_ctrl <= '0;
        end else begin
            win_ctrl.valid <= accept;
            win_ctrl.sop   <= sop_in;
            win_ctrl.eop   <= eop_in;
            win_ctrl.mode  <= kernel_sel;
            if (accept) begin
                if (int'(col_ptr) == line_len_p - 1) begin
                    col_ptr <= '0;
                end else begin
                    col_ptr <= col_ptr + 1'b1;
                end
            end
        end
    end

    // Window and line memories only move on an accepted pixel
    always_ff @(posedge clk) begin
        if (accept) begin
            for (int k = 0; k < max_k - 1; k++) begin
                line_mem[k][col_ptr] <= feed[k+1];
            end
            for (int r = 0; r < max_k; r++) begin
                for (int c = 0; c < max_k - 1; c++) begin
                    win_r[r][c] <= win_r[r][c+1];
                    win_g[r][c] <= win_g[r][c+1];
                    win_b[r][c] <= win_b[r][c+1];
                end
                win_r[r][max_k-1] <= feed[r].r;
                win_g[r][max_k-1] <= feed[r].g;
                win_b[r][max_k-1] <= feed[r].b;
            end
            win_pixel <= pixel_in;
        end
    end

    // Line memories are addressed only inside one line
    a_col_ptr_range: assert property (@(posedge clk) disable iff (rst)
        int'(col_ptr) < line_len_p);

endmodule

// File: design/channel_convolver.sv
`timescale 1ns/10ps

module channel_convolver (
    input  logic                   clk,
    input  logic                   rst,
    input  blur_pkg::blur_mode_t   mode,
    input  blur_pkg::chan_window_t window,
    output blur_pkg::chan_sum_t    sum
);
    import blur_pkg::*;

    // Stage 1 results, the right three columns are held for stage 2
    chan_sum_t                         left_s1 [max_k];
    logic [max_k-1:0][2:0][chan_w-1:0] right_s1;
    // Stage 2 complete row sums
    chan_sum_t                         row_s2 [max_k];
    blur_mode_t                        mode_s1;
    blur_mode_t                        mode_s2;
    blur_mode_t                        mode_s3;
    chan_sum_t                         left_next [max_k];
    chan_sum_t                         row_next [max_k];
    chan_sum_t                         total_next;

    // True when a row or column index lies in the centered kernel of the mode
    function automatic logic in_kernel(input int idx, input blur_mode_t m);
        int radius;
        radius = int'(m);
        return (m != mode_bypass) && (idx >= max_k / 2 - radius)
            && (idx <= max_k / 2 + radius);
    endfunction

    function automatic chan_sum_t weighted(input logic [chan_w-1:0] pix, input int row,
                                           input int col, input blur_mode_t m);
        chan_sum_t product;
        product = '0;
        if (in_kernel(row, m) && in_kernel(col, m)) begin
            product = chan_sum_t'(pix) * chan_sum_t'(kernel_weights[row][col]);
        end
        return product;
    endfunction

    function automatic int weight_total(input blur_mode_t m);
        int total;
        total = 0;
        for (int r = 0; r < max_k; r++) begin
            for (int c = 0; c < max_k; c++) begin
                if (in_kernel(r, m) && in_kernel(c, m)) begin
                    total += int'(kernel_weights[r][c]);
                end
            end
        end
        return total;
    endfunction

    // Left four columns of every row
    always_comb begin
        for (int r = 0; r < max_k; r++) begin
            left_next[r] = '0;
            for (int c = 0; c < 4; c++) begin
                left_next[r] += weighted(window[r][c], r, c, mode);
            end
        end
    end

    // Right three columns complete each row
    always_comb begin
        for (int r = 0; r < max_k; r++) begin
            row_next[r] = left_s1[r];
            for (int k = 0; k < 3; k++) begin
                row_next[r] += weighted(right_s1[r][k], r, 4 + k, mode_s1);
            end
        end
    end

    always_comb begin
        total_next = '0;
        for (int r = 0; r < max_k; r++) begin
            total_next += row_s2[r];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mode_s1 <= mode_bypass;
            mode_s2 <= mode_bypass;
            mode_s3 <= mode_bypass;
        end else begin
            mode_s1 <= mode;
            mode_s2 <= mode_s1;
            mode_s3 <= mode_s2;
        end
    end

    always_ff @(posedge clk) begin
        left_s1 <= left_next;
        for (int r = 0; r < max_k; r++) begin
            right_s1[r] <= window[r][max_k-1:4];
        end
        row_s2 <= row_next;
        sum    <= total_next;
    end

    // Sum bounded by the brightest channel times the weights of its own mode
    a_sum_bound: assert property (@(posedge clk) disable iff (rst)
        int'(sum) <= ((1 << chan_w) - 1) * weight_total(mode_s3));

endmodule

// File: design/pixel_normalizer.sv
`timescale 1ns/10ps

module pixel_normalizer (
    input  logic                   clk,
    input  logic                   rst,
    input  blur_pkg::stream_ctrl_t win_ctrl,
    input  blur_pkg::pixel_u       win_pixel,
    input  blur_pkg::chan_sum_t    sum_r,
    input  blur_pkg::chan_sum_t    sum_g,
    input  blur_pkg::chan_sum_t    sum_b,
    output logic                   valid_out,
    output logic                   sop_out,
    output logic                   eop_out,
    output blur_pkg::pixel_u       pixel_out
);
    import blur_pkg::*;

    // Three stages to line up with the convolver pipeline
    stream_ctrl_t ctrl_d [3];
    pixel_u       pix_d [3];
    pixel_u       blur_pix;

    // Divide by the weight total of the kernel, 32, 64 or 128
    function automatic logic [chan_w-1:0] normalize(input chan_sum_t s, input blur_mode_t m);
        chan_sum_t shifted;
        case (m)
            mode_k3: shifted = s >> 5;
            mode_k5: shifted = s >> 6;
            default: shifted = s >> 7;
        endcase
        return shifted[chan_w-1:0];
    endfunction

    always_comb begin
        blur_pix.rgb.r = normalize(sum_r, ctrl_d[2].mode);
        blur_pix.rgb.g = normalize(sum_g, ctrl_d[2].mode);
        blur_pix.rgb.b = normalize(sum_b, ctrl_d[2].mode);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 3; i++) begin
                ctrl_d[i] <= '0;
            end
            valid_out <= 1'b0;
            sop_out   <= 1'b0;
            eop_out   <= 1'b0;
        end else begin
            ctrl_d[0] <= win_ctrl;
            ctrl_d[1] <= ctrl_d[0];
            ctrl_d[2] <= ctrl_d[1];
            valid_out <= ctrl_d[2].valid;
            sop_out   <= ctrl_d[2].valid && ctrl_d[2].sop;
            eop_out   <= ctrl_d[2].valid && ctrl_d[2].eop;
        end
    end

    always_ff @(posedge clk) begin
        pix_d[0] <= win_pixel;
        pix_d[1] <= pix_d[0];
        pix_d[2] <= pix_d[1];
        // Bypass passes the raw word untouched
        if (ctrl_d[2].mode == mode_bypass) begin
            pixel_out.raw <= pix_d[2].raw;
        end else begin
            pixel_out <= blur_pix;
        end
    end

    // Packet markers only on a valid beat
    a_marker_valid: assert property (@(posedge clk) disable iff (rst)
        (sop_out || eop_out) |-> valid_out);

endmodule

// File: design/blur_filter_top.sv
`timescale 1ns/10ps

module blur_filter_top (
    input  logic                 clk,
    input  logic                 rst,
    input  blur_pkg::blur_mode_t kernel_sel,
    input  logic                 valid_in,
    input  logic                 ready_in,
    input  logic                 sop_in,
    input  logic                 eop_in,
    input  blur_pkg::pixel_u     pixel_in,
    output logic                 ready_out,
    output logic                 valid_out,
    output logic                 sop_out,
    output logic                 eop_out,
    output blur_pkg::pixel_u     pixel_out
);
    import blur_pkg::*;

    chan_window_t win_r;
    chan_window_t win_g;
    chan_window_t win_b;
    stream_ctrl_t win_ctrl;
    pixel_u       win_pixel;
    chan_sum_t    sum_r;
    chan_sum_t    sum_g;
    chan_sum_t    sum_b;

    // No output stall, ready goes straight upstream
    assign ready_out = ready_in;

    window_buffer #(
        .line_len_p (line_len)
    ) u_window (
        .clk        (clk),
        .rst        (rst),
        .valid_in   (valid_in),
        .ready_in   (ready_in),
        .sop_in     (sop_in),
        .eop_in     (eop_in),
        .kernel_sel (kernel_sel),
        .pixel_in   (pixel_in),
        .win_r      (win_r),
        .win_g      (win_g),
        .win_b      (win_b),
        .win_ctrl   (win_ctrl),
        .win_pixel  (win_pixel)
    );

    channel_convolver u_conv_r (
        .clk    (clk),
        .rst    (rst),
        .mode   (win_ctrl.mode),
        .window (win_r),
        .sum    (sum_r)
    );

    channel_convolver u_conv_g (
        .clk    (clk),
        .rst    (rst),
        .mode   (win_ctrl.mode),
        .window (win_g),
        .sum    (sum_g)
    );

    channel_convolver u_conv_b (
        .clk    (clk),
        .rst    (rst),
        .mode   (win_ctrl.mode),
        .window (win_b),
        .sum    (sum_b)
    );

    pixel_normalizer u_norm (
        .clk       (clk),
        .rst       (rst),
        .win_ctrl  (win_ctrl),
        .win_pixel (win_pixel),
        .sum_r     (sum_r),
        .sum_g     (sum_g),
        .sum_b     (sum_b),
        .valid_out (valid_out),
        .sop_out   (sop_out),
        .eop_out   (eop_out),
        .pixel_out (pixel_out)
    );

    // Every accepted pixel is registered out on the fourth edge, seen at the fifth sample
    a_fixed_latency: assert property (@(posedge clk) disable iff (rst)
        (valid_in && ready_in) |-> ##5 valid_out);

endmodule

// File: verification/blur_checker.sv
`timescale 1ns/10ps

module blur_checker (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 valid_in,
    input  logic                 ready_in,
    input  logic                 sop_in,
    input  logic                 eop_in,
    input  blur_pkg::pixel_u     pixel_in,
    input  logic                 ready_out,
    input  logic                 valid_out,
    input  logic                 sop_out,
    input  logic                 eop_out,
    input  blur_pkg::pixel_u     pixel_out,
    input  logic [8*16-1:0]      test_name,
    input  blur_pkg::blur_mode_t test_mode,
    input  int                   check_start,
    input  blur_pkg::pixel_u     expected,
    input  logic                 test_start,
    output int                   in_count,
    output int                   out_count,
    output int                   value_errors,
    output int                   protocol_errors
);
    import blur_pkg::*;

    // Output registered after the fourth edge is first seen by the fifth sample
    localparam int output_lag = 5;

    typedef struct packed {
        logic [pix_w-1:0] pixel;
        logic [1:0]       markers;
        blur_mode_t       mode;
        int               index;
        int               check_start;
        logic [pix_w-1:0] expected;
        int               cycle;
    } beat_t;

    beat_t pending [$];
    int    cycle;
    int    index;

    always @(posedge clk) begin
        beat_t            head;
        logic [pix_w-1:0] want;
        if (rst) begin
            pending.delete();
            cycle           = 0;
            index           = 0;
            in_count        = 0;
            out_count       = 0;
            value_errors    = 0;
            protocol_errors = 0;
        end else begin
            cycle++;
            if (ready_out !== ready_in) begin
                $display("ready_out does not follow ready_in at cycle %0d", cycle);
                protocol_errors++;
            end
            if ((sop_out || eop_out) && !valid_out) begin
                $display("sop_out or eop_out high without valid_out at cycle %0d", cycle);
                protocol_errors++;
            end
            if (valid_out && pending.size() == 0) begin
                $display("valid_out high with no accepted pixel pending at cycle %0d", cycle);
                protocol_errors++;
            end else if (valid_out) begin
                head = pending.pop_front();
                out_count++;
                // Bypass repeats the input, a blur of a full constant window returns the constant
                want = (head.mode == mode_bypass) ? head.pixel : head.expected;
                if ((head.mode == mode_bypass || head.index >= head.check_start)
                        && pixel_out.raw !== want) begin
                    $display("[ERROR] %0s pixel %0d: expected %03h, actual %03h",
                             test_name, head.index, want, pixel_out.raw);
                    value_errors++;
                end
                if ({sop_out, eop_out} !== head.markers) begin
                    $display("[ERROR] %0s sop/eop of pixel %0d: expected %02b, actual %02b",
                             test_name, head.index, head.markers, {sop_out, eop_out});
                    value_errors++;
                end
                if (cycle - head.cycle != output_lag) begin
                    $display("[ERROR] %0s latency of pixel %0d: expected %0d, actual %0d",
                             test_name, head.index, output_lag, cycle - head.cycle);
                    value_errors++;
                end
            end
            if (test_start) begin
                index = 0;
            end
            if (valid_in && ready_in) begin
                pending.push_back({pixel_in.raw, {sop_in, eop_in}, test_mode, index,
                                   check_start, expected.raw, cycle});
                index++;
                in_count++;
            end
        end
    end

endmodule

// File: verification/blur_tb.sv
`timescale 1ns/10ps

module blur_tb;
    import blur_pkg::*;

    localparam int    clk_period = 10;
    localparam string stim_file  = "verification/blur_stimulus.txt";

    logic             clk;
    logic             rst;
    blur_mode_t       kernel_sel;
    logic             valid_in;
    logic             ready_in;
    logic             sop_in;
    logic             eop_in;
    pixel_u           pixel_in;
    logic             ready_out;
    logic             valid_out;
    logic             sop_out;
    logic             eop_out;
    pixel_u           pixel_out;
    logic [8*16-1:0]  test_name;
    blur_mode_t       test_mode;
    int               check_start;
    pixel_u           expected;
    logic             test_start;
    int               in_count;
    int               out_count;
    int               value_errors;
    int               protocol_errors;
    int               timeout_errors;
    int               setup_errors;
    integer           seed = 35387;

    blur_filter_top DUT (.*);

    blur_checker u_checker (.*);

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    function automatic logic [pix_w-1:0] pick_pixel(input int pattern,
                                                    input logic [pix_w-1:0] rgb);
        int r;
        r = $random(seed);
        return pattern[0] ? r[pix_w-1:0] : rgb;
    endfunction

    // Valid stays low, markers and data carry junk
    task automatic idle_cycles(input int n, input logic toggle_ready);
        int r;
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
            r            = $random(seed);
            valid_in     = 1'b0;
            ready_in     = toggle_ready ? r[0] : 1'b1;
            sop_in       = r[1];
            eop_in       = r[2];
            pixel_in.raw = r[15:4];
        end
    endtask

    task automatic run_test(input logic [8*16-1:0] name, input int mode, input int pattern,
                            input logic [pix_w-1:0] rgb, input int count, input int start,
                            input logic [pix_w-1:0] want);
        int               idx;
        int               cycles;
        int               r;
        logic             gaps;
        logic [pix_w-1:0] pix;
        @(negedge clk);
        test_name    = name;
        test_mode    = blur_mode_t'(mode[1:0]);
        kernel_sel   = blur_mode_t'(mode[1:0]);
        check_start  = start;
        expected.raw = want;
        test_start   = 1'b1;
        @(negedge clk);
        test_start = 1'b0;
        gaps       = pattern >= 2;
        idx        = 0;
        cycles     = 0;
        pix        = pick_pixel(pattern, rgb);
        while (idx < count && cycles < 16 * count) begin
            @(negedge clk);
            r        = $random(seed);
            valid_in = !gaps || r[1:0] != 2'b00;
            ready_in = !gaps || r[3:2] != 2'b00;
            if (valid_in) begin
                pixel_in.raw = pix;
                // Markers at line boundaries and on the last pixel of the test
                sop_in = idx % line_len == 0;
                eop_in = idx % line_len == line_len - 1 || idx == count - 1;
            end else begin
                pixel_in.raw = r[15:4];
                sop_in       = r[4];
                eop_in       = r[5];
            end
            if (valid_in && ready_in) begin
                idx++;
                pix = pick_pixel(pattern, rgb);
            end
            cycles++;
        end
        if (idx < count) begin
            $display("Timeout in %0s: only %0d of %0d pixels accepted", name, idx, count);
            timeout_errors++;
        end
        @(negedge clk);
        valid_in = 1'b0;
        cycles   = 0;
        while (out_count != in_count && cycles < 64) begin
            @(negedge clk);
            cycles++;
        end
        if (out_count != in_count) begin
            $display("Timeout in %0s: %0d pixels accepted but %0d outputs seen",
                     name, in_count, out_count);
            timeout_errors++;
        end
        idle_cycles(8, 1'b1);
    endtask

    initial begin
        int               fd;
        int               n;
        int               tests;
        string            line;
        logic [8*16-1:0]  name;
        int               mode;
        int               pattern;
        logic [pix_w-1:0] rgb;
        int               count;
        int               start;
        logic [pix_w-1:0] want;
        rst            = 1'b1;
        kernel_sel     = mode_bypass;
        valid_in       = 1'b0;
        ready_in       = 1'b0;
        sop_in         = 1'b0;
        eop_in         = 1'b0;
        pixel_in       = '0;
        test_name      = '0;
        test_mode      = mode_bypass;
        check_start    = 0;
        expected       = '0;
        test_start     = 1'b0;
        timeout_errors = 0;
        setup_errors   = 0;
        tests          = 0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        // Quiet outputs after reset while ready toggles
        idle_cycles(40, 1'b1);
        fd = $fopen(stim_file, "r");
        if (fd == 0) begin
            $display("Could not open stimulus file %0s", stim_file);
            setup_errors++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                n = $sscanf(line, "%s %d %d %h %d %d %h",
                            name, mode, pattern, rgb, count, start, want);
                if (n == 7) begin
                    run_test(name, mode, pattern, rgb, count, start, want);
                    tests++;
                end
            end
            $fclose(fd);
            if (tests == 0) begin
                $display("No tests found in stimulus file %0s", stim_file);
                setup_errors++;
            end
        end
        $display("Errors: %0d value, %0d protocol, %0d timeout, %0d setup",
                 value_errors, protocol_errors, timeout_errors, setup_errors);
        if (value_errors + protocol_errors + timeout_errors + setup_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: build.f
design/blur_pkg.sv
design/window_buffer.sv
design/channel_convolver.sv
design/pixel_normalizer.sv
design/blur_filter_top.sv
verification/blur_checker.sv
verification/blur_tb.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --assert -j 0
TOP       := blur_tb
FILELIST  := build.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
PASS_MSG  := Testbench passed
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "Simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: verification/blur_stimulus.txt
# Columns are name, mode, pattern, rgb, count, check start index, expected pixel
# Mode 0 bypass 1 3x3 2 5x5 3 7x7 and pattern 0 constant 1 random 2 constant gaps 3 random gaps
bypass_random  0 1 000 700  0    000
bypass_gaps    0 3 000 500  0    000
k3_const       1 0 a5c 2100 1927 a5c
k5_const       2 0 3c7 2100 1927 3c7
k7_const       3 0 e29 2100 1927 e29
k7_white       3 0 fff 2050 1927 fff
k3_white       1 0 fff 2000 1927 fff
k5_gaps        2 2 5b1 2200 1927 5b1
k7_mixed       3 0 184 2000 1927 184
bypass_after   0 1 000 300  0    000
k3_dark        1 0 010 2000 1927 010
